// ==== sim.f ====
hw/mult_pkg.sv
hw/mult_ctrl_if.sv
hw/add_sub_unit.sv
hw/product_regs.sv
hw/mult_sequencer.sv
hw/serial_multiplier.sv
test/tb_serial_multiplier.sv

// ==== Makefile ====
# Verilator flow for the serial multiplier.

TOP = tb_serial_multiplier

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_serial_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_serial_multiplier import mult_pkg::*;;

	localparam int WIDTH = MULT_WIDTH;
	localparam int DONE_TIMEOUT = 40;	// Cycles allowed for one run.
	localparam int RANDOM_TRIALS = 20;
	localparam logic [15:0] LFSR_SEED = 16'd57;
	localparam operand_t CORNERS [5] = '{
		operand_t'(0), operand_t'(1), operand_t'(-1),
		operand_t'(1 << (WIDTH - 1)), operand_t'((1 << (WIDTH - 1)) - 1)
	};

	logic Clk = 1'b0;
	logic rst_n;
	operand_t switches;
	logic run;
	logic clear_load;
	logic x_out;
	operand_t a_out;
	operand_t b_out;
	logic done;

	int check_errors = 0;
	int timeouts = 0;
	logic [15:0] lfsr;

	// Reference model of the operator interface.
	int run_cnt;	// Edges since a run was accepted. It is zero when idle.
	bit load_pend;
	bit load_check;
	bit reset_check;
	bit run_accept;
	logic [2*WIDTH:0] done_pipe;
	logic done_exp;
	product_t exp_prod;
	logic model_x;
	operand_t model_a;
	operand_t model_b;

	serial_multiplier #(
		.WIDTH(WIDTH)
	) serial_multiplier_i (
		.Clk(Clk),
		.rst_n(rst_n),
		.switches(switches),
		.run(run),
		.clear_load(clear_load),
		.x_out(x_out),
		.a_out(a_out),
		.b_out(b_out),
		.done(done)
	);

	always #5 Clk = ~Clk;

	function automatic product_t signed_product(input operand_t b, input operand_t m);
		return product_t'(b) * product_t'(m);
	endfunction

	// Taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	assign run_accept = rst_n && (run_cnt == 0) && !load_pend && run;
	assign done_exp = done_pipe[2*WIDTH];	// Run accepted 2*WIDTH+1 edges ago.

	always @(posedge Clk) begin
		if (!rst_n) begin
			run_cnt <= 0;
			load_pend <= 1'b0;
			load_check <= 1'b0;
			reset_check <= 1'b1;
			done_pipe <= '0;
			exp_prod <= '0;
			{model_x, model_a, model_b} <= '0;
		end else begin
			reset_check <= 1'b0;
			load_check <= load_pend;
			done_pipe <= {done_pipe[2*WIDTH-1:0], run_accept};
			if (run_cnt != 0) begin
				if (run_cnt == 2 * WIDTH) begin
					run_cnt <= 0;	// The last shift leaves the product in place.
					{model_x, model_a, model_b} <= {exp_prod[2*WIDTH-1], exp_prod};
				end else begin
					run_cnt <= run_cnt + 1;
				end
			end else if (load_pend) begin
				load_pend <= 1'b0;
				{model_x, model_a, model_b} <= {1'b0, operand_t'(0), switches};
			end else if (run_accept) begin
				run_cnt <= 1;
				exp_prod <= signed_product(model_b, switches);
			end else if (clear_load) begin
				load_pend <= 1'b1;
			end
		end
	end

	a_reset_state : assert property (@(posedge Clk) disable iff (!rst_n)
		reset_check |-> ({x_out, a_out, b_out, done} == '0)
	) else begin
		check_errors++;
		$display("[ERROR] {x_out,a_out,b_out,done}: expected %h, got %h", {2*WIDTH+2{1'b0}},
			$sampled({x_out, a_out, b_out, done}));
	end

	a_load_result : assert property (@(posedge Clk) disable iff (!rst_n)
		load_check |-> ({x_out, a_out, b_out} == {1'b0, operand_t'(0), model_b})
	) else begin
		check_errors++;
		$display("[ERROR] {x_out,a_out,b_out}: expected %h, got %h",
			$sampled({1'b0, operand_t'(0), model_b}), $sampled({x_out, a_out, b_out}));
	end

	a_idle_hold : assert property (@(posedge Clk) disable iff (!rst_n)
		(run_cnt == 0 && !load_pend) |-> ({x_out, a_out, b_out} == {model_x, model_a, model_b})
	) else begin
		check_errors++;
		$display("[ERROR] {x_out,a_out,b_out}: expected %h, got %h",
			$sampled({model_x, model_a, model_b}), $sampled({x_out, a_out, b_out}));
	end

	a_done_timing : assert property (@(posedge Clk) disable iff (!rst_n)
		done == done_exp
	) else begin
		check_errors++;
		$display("[ERROR] done: expected %h, got %h", $sampled(done_exp), $sampled(done));
	end

	a_product : assert property (@(posedge Clk) disable iff (!rst_n)
		done_exp |-> ({a_out, b_out} == exp_prod)
	) else begin
		check_errors++;
		$display("[ERROR] {a_out,b_out}: expected %h, got %h",
			$sampled(exp_prod), $sampled({a_out, b_out}));
	end

	a_sign : assert property (@(posedge Clk) disable iff (!rst_n)
		done_exp |-> (x_out == exp_prod[2*WIDTH-1])
	) else begin
		check_errors++;
		$display("[ERROR] x_out: expected %h, got %h",
			$sampled(exp_prod[2*WIDTH-1]), $sampled(x_out));
	end

	task automatic next_cycle();
		@(posedge Clk);
		#1;
	endtask

	task automatic random_operand(output operand_t value);
		for (int i = 0; i < WIDTH; i++) begin
			lfsr = lfsr_next(lfsr);
			value[i] = lfsr[0];
		end
	endtask

	task automatic report_and_finish();
		$display("Check errors: %0d, timeouts: %0d", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < DONE_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (!done) begin
			timeouts++;
			$display("Timeout while waiting for done at the end of a run.");
			report_and_finish();
		end
	endtask

	// B is taken on the edge after the strobe is sampled.
	task automatic load_b(input operand_t value);
		switches = value;
		clear_load = 1'b1;
		next_cycle();
		clear_load = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic multiply(input operand_t mcand, input bit busy_strobes);
		switches = mcand;	// Held until the run ends.
		run = 1'b1;
		next_cycle();
		run = 1'b0;
		if (busy_strobes) begin
			repeat (4) next_cycle();
			run = 1'b1;
			clear_load = 1'b1;
			next_cycle();
			run = 1'b0;
			clear_load = 1'b0;
		end
		wait_for_done();
	endtask

	initial begin
		operand_t b_val;
		operand_t m_val;

		lfsr = LFSR_SEED;
		switches = '0;
		run = 1'b0;
		clear_load = 1'b0;
		rst_n = 1'b0;
		repeat (3) @(posedge Clk);
		#1 rst_n = 1'b1;
		repeat (3) next_cycle();

		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				load_b(CORNERS[i]);
				multiply(CORNERS[j], 1'b0);
			end
		end

		for (int n = 0; n < RANDOM_TRIALS; n++) begin
			random_operand(b_val);
			random_operand(m_val);
			load_b(b_val);
			multiply(m_val, 1'b0);
		end

		random_operand(b_val);
		random_operand(m_val);
		load_b(b_val);
		multiply(m_val, 1'b1);

		// Without a reload B keeps the low byte of the last product.
		random_operand(m_val);
		multiply(m_val, 1'b0);

		repeat (3) next_cycle();
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== hw/serial_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_multiplier import mult_pkg::*; #(
	parameter int WIDTH = MULT_WIDTH
) (
	input logic Clk,
	input logic rst_n,
	input operand_t switches,	// B on a load, the multiplicand during a run.
	input logic run,
	input logic clear_load,
	output logic x_out,
	output operand_t a_out,
	output operand_t b_out,
	output logic done
);

	// The operand types are sized from the package.
	if (WIDTH != MULT_WIDTH) begin : g_width_check
		$error("WIDTH must match MULT_WIDTH in mult_pkg.");
	end

	mult_ctrl_if ctrl ();

	ext_t sum;

	mult_sequencer #(
		.WIDTH(WIDTH)
	) mult_sequencer_i (
		.Clk(Clk),
		.rst_n(rst_n),
		.run(run),
		.clear_load(clear_load),
		.ctrl(ctrl.seq),
		.done(done)
	);

	add_sub_unit #(
		.WIDTH(WIDTH)
	) add_sub_unit_i (
		.a(a_out),
		.multiplicand(switches),
		.sub(ctrl.sub),
		.sum(sum)
	);

	product_regs #(
		.WIDTH(WIDTH)
	) product_regs_i (
		.Clk(Clk),
		.rst_n(rst_n),
		.switches(switches),
		.sum(sum),
		.ctrl(ctrl.regs),
		.x(x_out),
		.a(a_out),
		.b(b_out)
	);

endmodule

`default_nettype wire

// ==== hw/mult_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_sequencer import mult_pkg::*; #(
	parameter int WIDTH = MULT_WIDTH
) (
	input logic Clk,
	input logic rst_n,
	input logic run,
	input logic clear_load,
	mult_ctrl_if.seq ctrl,
	output logic done
);

	localparam int CNT_W = $clog2(WIDTH + 1);

	seq_state_t state;
	seq_state_t next_state;
	logic [CNT_W-1:0] bit_cnt;	// Index of the multiplier bit being worked on.
	logic start;
	logic last_bit;

	assign start = (state == IDLE) && run;	// Run has priority over clear_load.
	assign last_bit = (bit_cnt == CNT_W'(WIDTH - 1));

	// Strobes depend only on the state, the counter, m and run.
	always_comb begin
		next_state = state;
		ctrl.clr_ld = 1'b0;
		ctrl.clr_a = 1'b0;
		ctrl.add = 1'b0;
		ctrl.sub = 1'b0;
		ctrl.shift = 1'b0;

		unique case (state)
			IDLE: begin
				if (start) begin
					ctrl.clr_a = 1'b1;
					next_state = ADD;
				end else if (clear_load) begin
					next_state = LOAD;
				end
			end

			LOAD: begin
				ctrl.clr_ld = 1'b1;
				next_state = IDLE;
			end

			ADD: begin
				// The last bit of B is its sign bit, so it carries a negative weight.
				if (ctrl.m) begin
					if (last_bit)
						ctrl.sub = 1'b1;
					else
						ctrl.add = 1'b1;
				end
				next_state = SHIFT;
			end

			SHIFT: begin
				ctrl.shift = 1'b1;
				next_state = last_bit ? IDLE : ADD;
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			state <= IDLE;
			bit_cnt <= '0;
			done <= 1'b0;
		end else begin
			state <= next_state;
			// Goes high on the same edge that writes the final shift.
			done <= (state == SHIFT) && last_bit;
			if (start)
				bit_cnt <= '0;
			else if (state == SHIFT && !last_bit)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	a_strobes_exclusive : assert property (
		@(posedge Clk) disable iff (!rst_n)
		$onehot0({ctrl.clr_ld, ctrl.add, ctrl.sub, ctrl.shift})
	) else $error("More than one of clr_ld, add, sub and shift is active.");

	a_cnt_in_range : assert property (
		@(posedge Clk) disable iff (!rst_n)
		bit_cnt <= CNT_W'(WIDTH - 1)
	) else $error("Bit counter went past the last multiplier bit.");

endmodule

`default_nettype wire

// ==== hw/product_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_regs import mult_pkg::*; #(
	parameter int WIDTH = MULT_WIDTH
) (
	input logic Clk,
	input logic rst_n,
	input operand_t switches,
	input ext_t sum,
	mult_ctrl_if.regs ctrl,
	output logic x,
	output operand_t a,
	output operand_t b
);

	product_t ab_shifted;

	// X fills the top of A and also stays in place, so the shift is arithmetic.
	// The low bit of A drops into the top of B and B's low bit falls off.
	assign ab_shifted = {x, a, b[WIDTH-1:1]};

	assign ctrl.m = b[0];	// The next multiplier bit to examine.

	always_ff @(posedge Clk) begin
		if (!rst_n) begin
			x <= 1'b0;
			a <= '0;
			b <= '0;
		end else if (ctrl.clr_ld) begin
			x <= 1'b0;
			a <= '0;
			b <= switches;
		end else if (ctrl.clr_a) begin
			x <= 1'b0;	// B is left alone so a run can chain on the last product.
			a <= '0;
		end else if (ctrl.add || ctrl.sub) begin
			{x, a} <= sum;
		end else if (ctrl.shift) begin
			a <= ab_shifted[2*WIDTH-1:WIDTH];
			b <= ab_shifted[WIDTH-1:0];
		end
	end

	a_add_sub_exclusive : assert property (
		@(posedge Clk) disable iff (!rst_n)
		!(ctrl.add && ctrl.sub)
	) else $error("add and sub were requested in the same cycle.");

	// Every partial sum is followed by its shift.
	a_sum_then_shift : assert property (
		@(posedge Clk) disable iff (!rst_n)
		(ctrl.add || ctrl.sub) |=> ctrl.shift
	) else $error("A partial sum was not followed by a shift.");

endmodule

`default_nettype wire

// ==== hw/add_sub_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit import mult_pkg::*; #(
	parameter int WIDTH = MULT_WIDTH
) (
	input operand_t a,
	input operand_t multiplicand,
	input logic sub,
	output ext_t sum
);

	ext_t a_ext;
	ext_t m_ext;
	ext_t m_op;
	ext_t carry_in;

	// One extra sign bit keeps the sum of two signed bytes from overflowing.
	assign a_ext = {a[WIDTH-1], a};
	assign m_ext = {multiplicand[WIDTH-1], multiplicand};

	// Subtraction is the inverted multiplicand plus one.
	assign m_op = sub ? ~m_ext : m_ext;
	assign carry_in = {{WIDTH{1'b0}}, sub};

	assign sum = a_ext + m_op + carry_in;	// Bit WIDTH becomes the new X.

endmodule

`default_nettype wire

// ==== hw/mult_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Control strobes from the sequencer to the register file, and the
// current multiplier bit going back the other way.
interface mult_ctrl_if;

	logic clr_ld;	// Load B from the switches and clear X and A.
	logic clr_a;	// Clear X and A when a run starts.
	logic add;	// Write A plus the multiplicand into {X, A}.
	logic sub;	// Write A minus the multiplicand into {X, A}.
	logic shift;	// Arithmetic shift of {X, A, B} right by one.
	logic m;	// Low bit of B.

	modport seq (
		output clr_ld,
		output clr_a,
		output add,
		output sub,
		output shift,
		input m
	);

	modport regs (
		input clr_ld,
		input clr_a,
		input add,
		input sub,
		input shift,
		output m
	);

endinterface

`default_nettype wire

// ==== hw/mult_pkg.sv ====
`default_nettype none

package mult_pkg;

	// Operand width of the multiplier. The top level passes it down as WIDTH.
	parameter int MULT_WIDTH = 8;

	// One operand byte, as seen on the switches and in registers A and B.
	typedef logic signed [MULT_WIDTH-1:0] operand_t;

	// Sign-extended partial sum. The top bit becomes the new X.
	typedef logic signed [MULT_WIDTH:0] ext_t;

	// Full product held in {A, B} once the run is finished.
	typedef logic signed [2*MULT_WIDTH-1:0] product_t;

	// Each multiplier bit takes one ADD cycle followed by one SHIFT cycle.
	typedef enum logic [1:0] {
		IDLE,	// Waiting for run or clear_load.
		LOAD,	// Loads B and clears X and A.
		ADD,	// Adds or subtracts the multiplicand when m is set.
		SHIFT	// Shifts {X, A, B} right by one place.
	} seq_state_t;

endpackage

`default_nettype wire
